//--- common/divsqrt_pkg.sv
package divsqrt_pkg;

  // ----------------------------------------------------------
  // formats
  // ----------------------------------------------------------
  localparam int unsigned MANT_BITS = 23;  // stored fraction bits
  localparam int          EXP_BIAS  = 127;

  typedef logic [31:0]          fp32_t;    // ieee single word
  typedef logic [MANT_BITS:0]   mant_t;    // significand incl hidden bit
  typedef logic signed [9:0]    exp_t;     // wide enough to see over/underflow
  typedef logic [4:0]           status_t;  // nv dz of uf nx

  typedef enum logic {
    OP_DIV,
    OP_SQRT
  } op_e;

  // ----------------------------------------------------------
  // flag positions inside status_t
  // ----------------------------------------------------------
  localparam int unsigned FLAG_NV = 4;  // invalid
  localparam int unsigned FLAG_DZ = 3;  // divide by zero
  localparam int unsigned FLAG_OF = 2;
  localparam int unsigned FLAG_UF = 1;
  localparam int unsigned FLAG_NX = 0;  // inexact

  // quiet nan returned for every invalid case
  localparam fp32_t CANON_QNAN = 32'h7fc0_0000;

endpackage

//--- common/divsqrt_unit_if.sv
interface divsqrt_unit_if import divsqrt_pkg::*; ();

  // request side
  logic    start;      // one cycle pulse while ready
  op_e     op;
  fp32_t   operand_a;
  fp32_t   operand_b;  // unused for sqrt

  // response side
  logic    ready;      // high again in the done cycle
  logic    done;       // one cycle pulse
  fp32_t   result;
  status_t status;

  modport ctrl (
    output start, op, operand_a, operand_b,
    input  ready, done, result, status
  );

  modport unit (
    input  start, op, operand_a, operand_b,
    output ready, done, result, status
  );

endinterface

//--- src/elastic_pipe.sv
module elastic_pipe #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumRegs   = 1   // 0 gives a straight connection
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 busy_o
);

  // index i is the signal after i stages
  logic [NumRegs:0]     valid;
  logic [NumRegs:0]     ready;  // combinational back to front
  logic [DataWidth-1:0] data [NumRegs+1];

  assign valid[0]       = valid_i;
  assign data[0]        = data_i;
  assign ready_o        = ready[0];
  assign ready[NumRegs] = ready_i;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic                 vld_q;
    logic [DataWidth-1:0] data_q;

    // advance when next stage takes the item or holds only a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        vld_q <= 1'b0;
      end else if (flush_i) begin
        vld_q <= 1'b0;            // drop whatever is in flight
      end else if (ready[i]) begin
        vld_q <= valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready[i] && valid[i]) begin
        data_q <= data[i];        // load on accepted items only
      end
    end

    assign valid[i+1] = vld_q;
    assign data[i+1]  = data_q;
  end

  assign valid_o = valid[NumRegs];
  assign data_o  = data[NumRegs];
  assign busy_o  = |(valid >> 1);  // stage valids only, not the input

endmodule

//--- divsqrt_unit/divsqrt_iter.sv
module divsqrt_iter import divsqrt_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  logic        start_i,
  input  logic        is_sqrt_i,
  input  mant_t       mant_a_i,   // dividend or radicand
  input  mant_t       mant_b_i,   // divisor, lsb is odd flag for sqrt
  output logic        done_o,
  output logic [25:0] quot_o,     // lead bit at 25 or 24
  output logic        sticky_o
);

  localparam logic [4:0] DivSteps  = 5'd26;  // 1 int + 25 frac bits
  localparam logic [4:0] SqrtSteps = 5'd25;  // 24 sig bits + guard

  logic [4:0]  cnt_q, cnt_d;                 // steps still to run
  logic        done_q, step_en;
  logic        sqrt_q, sqrt_cur;
  mant_t       divisor_q, div_cur;
  logic [27:0] rem_q, rem_cur, rem_in, rem_sel, rem_next, sub;
  logic [28:0] diff;
  logic        ge;
  logic [25:0] quot_q, quot_cur, rad_q, rad_cur;

  // first step runs on the start edge from the fresh operands
  assign sqrt_cur = start_i ? is_sqrt_i : sqrt_q;
  assign div_cur  = start_i ? mant_b_i : divisor_q;
  assign quot_cur = start_i ? '0 : quot_q;
  assign rem_cur  = start_i ? (is_sqrt_i ? '0 : {4'b0, mant_a_i}) : rem_q;
  assign rad_cur  = !start_i ? rad_q :
                    mant_b_i[0] ? {mant_a_i, 2'b00} : {1'b0, mant_a_i, 1'b0};

  // one shared trial subtract per cycle
  assign rem_in   = sqrt_cur ? {rem_cur[25:0], rad_cur[25:24]} : rem_cur;
  assign sub      = sqrt_cur ? {quot_cur, 2'b01} : {4'b0, div_cur};
  assign diff     = {1'b0, rem_in} - {1'b0, sub};
  assign ge       = ~diff[28];               // no borrow so bit is 1
  assign rem_sel  = ge ? diff[27:0] : rem_in;  // restore on borrow
  assign rem_next = sqrt_cur ? rem_sel : {rem_sel[26:0], 1'b0};

  assign step_en = start_i | (cnt_q != '0);
  assign cnt_d   = (start_i ? (is_sqrt_i ? SqrtSteps : DivSteps) : cnt_q) - 5'd1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      if (step_en) cnt_q <= cnt_d;
      done_q <= step_en && (cnt_d == '0);    // pulse after the last step
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rem_q     <= rem_next;
      quot_q    <= {quot_cur[24:0], ge};
      rad_q     <= {rad_cur[23:0], 2'b00};   // two radicand bits per step
      divisor_q <= div_cur;
      sqrt_q    <= sqrt_cur;
    end
  end

  assign done_o   = done_q;
  assign quot_o   = sqrt_q ? {quot_q[24:0], 1'b0} : quot_q;  // root aligned to bit 25
  assign sticky_o = (rem_q != '0);

endmodule

//--- divsqrt_unit/divsqrt_round.sv
module divsqrt_round import divsqrt_pkg::*; (
  input  logic        sign_i,
  input  exp_t        exp_i,     // biased, valid for lead bit at 25
  input  logic [25:0] quot_i,
  input  logic        sticky_i,
  output fp32_t       result_o,
  output status_t     status_o
);

  logic        norm;             // lead bit sits at 25
  mant_t       sig;
  logic        guard, sticky, round_up, inexact;
  logic [24:0] sum;              // rounded significand with carry out
  exp_t        exp_n, exp_r;

  // ----------------------------------------------------------
  // normalize by at most one bit
  // ----------------------------------------------------------
  assign norm   = quot_i[25];
  assign sig    = norm ? quot_i[25:2] : quot_i[24:1];
  assign guard  = norm ? quot_i[1] : quot_i[0];
  assign sticky = sticky_i | (norm & quot_i[0]);
  assign exp_n  = norm ? exp_i : exp_i - exp_t'(1);

  // round to nearest, ties to even
  assign inexact  = guard | sticky;
  assign round_up = guard & (sticky | sig[0]);
  assign sum      = {1'b0, sig} + 25'(round_up);
  assign exp_r    = exp_n + exp_t'(sum[24]);  // 1.111 rounding up to 10.000

  always_comb begin
    status_o = '0;
    if (exp_r >= exp_t'(255)) begin
      result_o          = {sign_i, 8'hff, 23'b0};   // too large
      status_o[FLAG_OF] = 1'b1;
      status_o[FLAG_NX] = 1'b1;
    end else if (exp_r <= exp_t'(0)) begin
      result_o          = {sign_i, 31'b0};          // tiny flushes to zero
      status_o[FLAG_UF] = 1'b1;
      status_o[FLAG_NX] = 1'b1;
    end else begin
      // on carry out sum[22:0] is already zero
      result_o          = {sign_i, exp_r[7:0], sum[MANT_BITS-1:0]};
      status_o[FLAG_NX] = inexact;
    end
  end

endmodule

//--- divsqrt_unit/divsqrt_unit.sv
module divsqrt_unit import divsqrt_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         flush_i,
  divsqrt_unit_if.unit port
);

  typedef enum logic [1:0] {U_IDLE, U_CLASS, U_ITER} unit_state_e;

  unit_state_e state_q;
  op_e         op_q;
  fp32_t       a_q, b_q;       // operands as issued
  logic        sign_q;
  exp_t        exp_q;          // biased, for lead bit at quot[25]
  logic [7:0]  a_exp, b_exp;
  logic        a_zero, a_inf, a_nan, a_snan;
  logic        b_zero, b_inf, b_nan, b_snan;
  logic        is_sqrt, sign_div, special, iter_start, iter_done, sticky;
  logic        sq_odd;
  exp_t        sq_exp, sq_half, exp_d;
  mant_t       mant_a, mant_b;
  logic [25:0] quot;
  fp32_t       spec_result, rnd_result;
  status_t     spec_status, rnd_status;

  always_ff @(posedge clk_i) begin
    if (port.start) begin
      op_q <= port.op;
      a_q  <= port.operand_a;
      b_q  <= port.operand_b;
    end
  end

  // ----------------------------------------------------------
  // classify, subnormals count as zero
  // ----------------------------------------------------------
  assign is_sqrt  = (op_q == OP_SQRT);
  assign sign_div = a_q[31] ^ b_q[31];
  assign a_exp    = a_q[30:MANT_BITS];
  assign b_exp    = b_q[30:MANT_BITS];
  assign a_zero   = (a_exp == 8'h00);
  assign b_zero   = (b_exp == 8'h00);
  assign a_inf    = (a_exp == 8'hff) && (a_q[MANT_BITS-1:0] == '0);
  assign b_inf    = (b_exp == 8'hff) && (b_q[MANT_BITS-1:0] == '0);
  assign a_nan    = (a_exp == 8'hff) && (a_q[MANT_BITS-1:0] != '0);
  assign b_nan    = (b_exp == 8'hff) && (b_q[MANT_BITS-1:0] != '0);
  assign a_snan   = a_nan & ~a_q[MANT_BITS-1];  // quiet bit clear
  assign b_snan   = b_nan & ~b_q[MANT_BITS-1];

  always_comb begin
    special     = 1'b1;
    spec_result = CANON_QNAN;
    spec_status = '0;
    if (is_sqrt) begin
      if (a_nan)        spec_status[FLAG_NV] = a_snan;
      else if (a_zero)  spec_result = {a_q[31], 31'b0};  // sqrt(-0) is -0
      else if (a_q[31]) spec_status[FLAG_NV] = 1'b1;     // negative operand
      else if (a_inf)   spec_result = {1'b0, 8'hff, 23'b0};
      else              special = 1'b0;
    end else begin
      if (a_nan || b_nan) begin
        spec_status[FLAG_NV] = a_snan | b_snan;
      end else if ((a_inf && b_inf) || (a_zero && b_zero)) begin
        spec_status[FLAG_NV] = 1'b1;
      end else if (a_inf || b_zero) begin
        spec_result          = {sign_div, 8'hff, 23'b0};
        spec_status[FLAG_DZ] = ~a_inf;                 // finite over zero
      end else if (a_zero || b_inf) begin
        spec_result = {sign_div, 31'b0};
      end else begin
        special = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // exponent and loop operands
  // ----------------------------------------------------------
  assign sq_exp  = exp_t'({2'b00, a_exp}) - exp_t'(EXP_BIAS);  // unbiased
  assign sq_odd  = sq_exp[0];
  assign sq_half = (sq_exp - exp_t'(sq_odd)) >>> 1;
  assign exp_d   = is_sqrt ? sq_half + exp_t'(EXP_BIAS)
                           : exp_t'({2'b00, a_exp}) - exp_t'({2'b00, b_exp})
                             + exp_t'(EXP_BIAS);
  assign mant_a  = {1'b1, a_q[MANT_BITS-1:0]};
  // sqrt has no divisor so b carries the odd exponent pre-shift
  assign mant_b  = is_sqrt ? mant_t'(sq_odd) : {1'b1, b_q[MANT_BITS-1:0]};

  assign iter_start = (state_q == U_CLASS) & ~special & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (iter_start) begin
      sign_q <= is_sqrt ? 1'b0 : sign_div;
      exp_q  <= exp_d;
    end
  end

  divsqrt_iter u_iter (
    .clk_i, .rst_n_i, .flush_i,
    .start_i (iter_start), .is_sqrt_i (is_sqrt),
    .mant_a_i (mant_a), .mant_b_i (mant_b),
    .done_o (iter_done), .quot_o (quot), .sticky_o (sticky)
  );

  divsqrt_round u_round (
    .sign_i (sign_q), .exp_i (exp_q), .quot_i (quot), .sticky_i (sticky),
    .result_o (rnd_result), .status_o (rnd_status)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      state_q <= U_IDLE;                   // flush aborts the loop
    end else begin
      unique case (state_q)
        U_IDLE:  if (port.start) state_q <= U_CLASS;
        U_CLASS: state_q <= !special ? U_ITER : (port.start ? U_CLASS : U_IDLE);
        U_ITER:  if (iter_done) state_q <= port.start ? U_CLASS : U_IDLE;
        default: state_q <= U_IDLE;
      endcase
    end
  end

  assign port.done   = ((state_q == U_CLASS) & special) | ((state_q == U_ITER) & iter_done);
  assign port.ready  = (state_q == U_IDLE) | port.done;
  assign port.result = (state_q == U_CLASS) ? spec_result : rnd_result;
  assign port.status = (state_q == U_CLASS) ? spec_status : rnd_status;

endmodule

//--- src/divsqrt_ctrl.sv
module divsqrt_ctrl import divsqrt_pkg::*; #(
  parameter  int unsigned TagWidth = 4,
  localparam int unsigned InWidth  = 2 * $bits(fp32_t) + TagWidth + 1,
  localparam int unsigned OutWidth = $bits(fp32_t) + $bits(status_t) + TagWidth
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [InWidth-1:0]  in_data_i,   // {op, tag, a, b}
  divsqrt_unit_if.ctrl        unit,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [OutWidth-1:0] out_data_o,  // {result, status, tag}
  output logic                busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e              state_q, state_d;
  logic                in_ready;       // fsm accepts the next item
  logic                hold_result;    // capture unit result
  logic                data_is_held;   // output comes from hold register
  logic [TagWidth-1:0] tag_q;
  fp32_t               held_result_q, result_sel;
  status_t             held_status_q, status_sel;

  // unpack the input item straight onto the unit request
  assign unit.op        = op_e'(in_data_i[InWidth-1]);
  assign unit.operand_a = in_data_i[$bits(fp32_t) +: $bits(fp32_t)];
  assign unit.operand_b = in_data_i[0 +: $bits(fp32_t)];

  assign in_ready_o = in_ready & ~flush_i;
  assign unit.start = in_valid_i & in_ready_o;

  // ----------------------------------------------------------
  // control fsm
  // ----------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    in_ready     = 1'b0;
    out_valid_o  = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    busy_o       = 1'b0;
    unique case (state_q)
      IDLE: begin
        in_ready = unit.ready;
        if (in_valid_i && unit.ready) state_d = BUSY;
      end
      BUSY: begin
        busy_o = 1'b1;
        if (unit.done) begin
          out_valid_o = 1'b1;           // offer result right away
          if (out_ready_i) begin
            state_d = IDLE;
            if (in_valid_i && unit.ready) begin
              in_ready = 1'b1;          // back to back issue
              state_d  = BUSY;
            end
          end else begin
            hold_result = 1'b1;         // downstream stalled
            state_d     = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o       = 1'b1;
        data_is_held = 1'b1;
        out_valid_o  = 1'b1;
        if (out_ready_i) begin
          state_d = IDLE;
          if (in_valid_i && unit.ready) begin
            in_ready = 1'b1;
            state_d  = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  // tag follows the operation, captured at start
  always_ff @(posedge clk_i) begin
    if (unit.start) tag_q <= in_data_i[2*$bits(fp32_t) +: TagWidth];
  end

  always_ff @(posedge clk_i) begin
    if (hold_result) begin
      held_result_q <= unit.result;
      held_status_q <= unit.status;
    end
  end

  assign result_sel = data_is_held ? held_result_q : unit.result;
  assign status_sel = data_is_held ? held_status_q : unit.status;
  assign out_data_o = {result_sel, status_sel, tag_q};

endmodule

//--- src/divsqrt_top.sv
module divsqrt_top import divsqrt_pkg::*; #(
  parameter int unsigned TagWidth   = 4,
  parameter int unsigned NumInRegs  = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fp32_t               operand_a_i,
  input  fp32_t               operand_b_i,  // ignored for sqrt
  input  op_e                 op_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  output fp32_t               result_o,
  output status_t             status_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  // packed stream widths, must match divsqrt_ctrl
  localparam int unsigned InWidth  = 2 * $bits(fp32_t) + TagWidth + 1;
  localparam int unsigned OutWidth = $bits(fp32_t) + $bits(status_t) + TagWidth;

  logic [InWidth-1:0]  in_data;        // {op, tag, a, b}
  logic [InWidth-1:0]  ctrl_in_data;
  logic                ctrl_in_valid;
  logic                ctrl_in_ready;
  logic [OutWidth-1:0] ctrl_out_data;  // {result, status, tag}
  logic [OutWidth-1:0] out_data;
  logic                ctrl_out_valid;
  logic                ctrl_out_ready;
  logic                in_busy, ctrl_busy, out_busy;

  divsqrt_unit_if unit_if ();

  assign in_data = {op_i, tag_i, operand_a_i, operand_b_i};

  elastic_pipe #(.DataWidth(InWidth), .NumRegs(NumInRegs)) u_in_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_data),
    .valid_o (ctrl_in_valid),
    .ready_i (ctrl_in_ready),
    .data_o  (ctrl_in_data),
    .busy_o  (in_busy)
  );

  divsqrt_ctrl #(.TagWidth(TagWidth)) u_ctrl (
    .clk_i, .rst_n_i, .flush_i,
    .in_valid_i  (ctrl_in_valid),
    .in_ready_o  (ctrl_in_ready),
    .in_data_i   (ctrl_in_data),
    .unit        (unit_if.ctrl),
    .out_valid_o (ctrl_out_valid),
    .out_ready_i (ctrl_out_ready),
    .out_data_o  (ctrl_out_data),
    .busy_o      (ctrl_busy)
  );

  divsqrt_unit u_unit (.clk_i, .rst_n_i, .flush_i, .port(unit_if.unit));

  elastic_pipe #(.DataWidth(OutWidth), .NumRegs(NumOutRegs)) u_out_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (ctrl_out_valid),
    .ready_o (ctrl_out_ready),
    .data_i  (ctrl_out_data),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data),
    .busy_o  (out_busy)
  );

  assign {result_o, status_o, tag_o} = out_data;
  assign busy_o = in_busy | ctrl_busy | out_busy;  // anything in flight

endmodule

//--- verif/tb_divsqrt_tests.svh
// ------------------------------------------------------------
// directed tests, each drives the dut and checks its answers
// ------------------------------------------------------------

// short significands, quotient exact
task automatic exact_div_cases();
  run_op(32'h40c0_0000, 32'h4000_0000, OP_DIV, 32'h4040_0000, 5'b00000, "6/2");
  run_op(32'hc0f0_0000, 32'h4020_0000, OP_DIV, 32'hc040_0000, 5'b00000, "-7.5/2.5");
  run_op(32'h3f80_0000, 32'h4080_0000, OP_DIV, 32'h3e80_0000, 5'b00000, "1/4");
endtask

// quotient and divisor of at most 12 bits give an exact dividend
task automatic make_exact_div(output fp32_t dividend, output fp32_t divisor,
                              output fp32_t quot);
  logic [31:0] r_sig, r_exp;
  logic [23:0] mq, md;
  int          eq, ed;
  r_sig    = next_rand();
  r_exp    = next_rand();
  mq       = {12'b0, 1'b1, r_sig[26:16]};  // 12 bits, top one set
  md       = {12'b0, 1'b1, r_sig[10:0]};
  eq       = int'(r_exp[4:0]) - 16;        // small exponents stay normal
  ed       = int'(r_exp[12:8]) - 16;
  quot     = pack_fp(r_exp[20] ^ r_exp[21], eq, mq);
  divisor  = pack_fp(r_exp[21], ed, md);
  dividend = pack_fp(r_exp[20], eq + ed, mq * md);
endtask

task automatic random_div_cases();
  fp32_t a, b, q;
  int    n;
  for (n = 0; n < RandOps; n++) begin
    make_exact_div(a, b, q);
    run_op(a, b, OP_DIV, q, 5'b00000, $sformatf("random div %0d", n));
  end
endtask

task automatic sqrt_cases();
  run_op(32'h4180_0000, '0, OP_SQRT, 32'h4080_0000, 5'b00000, "sqrt 16");
  run_op(32'h4010_0000, '0, OP_SQRT, 32'h3fc0_0000, 5'b00000, "sqrt 2.25");
  run_op(32'h4110_0000, '0, OP_SQRT, 32'h4040_0000, 5'b00000, "sqrt 9");  // odd exp
  run_op(32'h4000_0000, '0, OP_SQRT, 32'h3fb5_04f3, 5'b00001, "sqrt 2");
  run_op(32'hbf80_0000, '0, OP_SQRT, CANON_QNAN, 5'b10000, "sqrt -1");
  run_op(32'h8000_0000, '0, OP_SQRT, 32'h8000_0000, 5'b00000, "sqrt -0");
endtask

task automatic div_special_cases();
  run_op(32'h3f80_0000, 32'h0000_0000, OP_DIV, 32'h7f80_0000, 5'b01000, "1/0");
  run_op(32'hc000_0000, 32'h0000_0000, OP_DIV, 32'hff80_0000, 5'b01000, "-2/0");
  run_op(32'h0000_0000, 32'h0000_0000, OP_DIV, CANON_QNAN, 5'b10000, "0/0");
  run_op(32'h7f80_0000, 32'hff80_0000, OP_DIV, CANON_QNAN, 5'b10000, "inf/-inf");
  run_op(32'h7f80_0001, 32'h3f80_0000, OP_DIV, CANON_QNAN, 5'b10000, "snan/1");
  run_op(32'h7fc1_2345, 32'h3f80_0000, OP_DIV, CANON_QNAN, 5'b00000, "qnan/1");
  run_op(32'h3f80_0000, 32'h4040_0000, OP_DIV, 32'h3eaa_aaab, 5'b00001, "1/3");
  run_op(32'h7f7f_ffff, 32'h3f00_0000, OP_DIV, 32'h7f80_0000, 5'b00101, "max/0.5");
endtask

// issue with out_ready low, then drain and check order
task automatic backpressure_order();
  fp32_t               a [BpOps];
  fp32_t               b [BpOps];
  fp32_t               q [BpOps];
  logic [TagWidth-1:0] t [BpOps];
  fp32_t               prev_res;
  status_t             prev_st;
  logic [TagWidth-1:0] prev_tag;
  logic                prev_valid;
  int                  i, n, got;
  for (i = 0; i < BpOps; i++) begin
    make_exact_div(a[i], b[i], q[i]);
    t[i] = TagWidth'(i + 3);
  end
  out_ready  = 1'b0;
  prev_valid = 1'b0;
  fork
    begin
      for (i = 0; i < BpOps; i++) issue_op(a[i], b[i], OP_DIV, t[i]);  // blocks when full
    end
    begin
      for (n = 0; n < StallCycles; n++) begin
        @(negedge clk);
        if (prev_valid) begin  // offered word must not move
          check_val(result, prev_res, "held result");
          check_val(32'(status), 32'(prev_st), "held status");
          check_val(32'(tag_out), 32'(prev_tag), "held tag");
        end
        prev_valid = out_valid;
        prev_res   = result;
        prev_st    = status;
        prev_tag   = tag_out;
      end
      check_val(32'(out_valid), 32'd1, "out_valid during stall");
      check_val(32'(busy), 32'd1, "busy during stall");
      next_drive();
      out_ready = 1'b1;
      got       = 0;
      while (got < BpOps) begin
        @(negedge clk);
        if (out_valid) begin
          check_val(result, q[got], $sformatf("stalled op %0d result", got));
          check_val(32'(status), 32'd0, $sformatf("stalled op %0d status", got));
          check_val(32'(tag_out), 32'(t[got]), $sformatf("stalled op %0d tag", got));
          got++;
        end
      end
      for (n = 0; n < IdleCycles; n++) begin
        @(negedge clk);
        check_val(32'(out_valid), 32'd0, "extra result after drain");
      end
      next_drive();
    end
  join
endtask

// two ops in flight, flush, then one clean op
task automatic flush_abort();
  fp32_t a, b, q;
  int    n;
  out_ready = 1'b1;
  make_exact_div(a, b, q);
  issue_op(a, b, OP_DIV, TagWidth'(13));
  make_exact_div(a, b, q);
  issue_op(a, b, OP_SQRT, TagWidth'(14));  // waits in the input stage
  repeat (4) next_drive();
  flush = 1'b1;
  next_drive();
  flush = 1'b0;
  @(negedge clk);
  check_val(32'(out_valid), 32'd0, "out_valid after flush");
  check_val(32'(busy), 32'd0, "busy after flush");
  for (n = 0; n < IdleCycles; n++) begin
    @(negedge clk);
    check_val(32'(out_valid), 32'd0, "flushed result appeared");
  end
  next_drive();
  make_exact_div(a, b, q);
  run_op(a, b, OP_DIV, q, 5'b00000, "div after flush");
endtask

//--- verif/tb_divsqrt.sv
module tb_divsqrt import divsqrt_pkg::*; ();

  localparam int unsigned TagWidth = 4;  // matches the dut default

  // ----------------------------------------------------------
  // run length, one entry per test
  // ----------------------------------------------------------
  localparam int ExactOps    = 3;
  localparam int RandOps     = 16;
  localparam int SqrtOps     = 6;
  localparam int SpecOps     = 8;
  localparam int BpOps       = 6;
  localparam int FlushOps    = 3;
  localparam int StallCycles = 120;  // out_ready low this long
  localparam int IdleCycles  = 80;   // watch window after flush and drain
  localparam int TotalOps    = ExactOps + RandOps + SqrtOps + SpecOps + BpOps + FlushOps;
  localparam int MaxCycles   = 200 * TotalOps + StallCycles + 2 * IdleCycles + 500;

  logic                clk, rst_n;
  fp32_t               operand_a, operand_b, result;
  op_e                 op;
  logic [TagWidth-1:0] tag, tag_out;
  logic [TagWidth-1:0] tag_seq;     // next tag for run_op
  logic                in_valid, in_ready, flush;
  logic                out_valid, out_ready, busy;
  status_t             status;
  logic [31:0]         lcg_state;
  int                  err_cnt, check_cnt, cycle_cnt;

  divsqrt_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_i        (op),
    .tag_i       (tag),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (tag_out),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  always #10 clk = ~clk;  // period 20

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  // inputs change 2 units after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
    check_cnt++;
    if (got !== expected) begin
      err_cnt++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
    return lcg_state;
  endfunction

  // builds (-1)^sgn * mag * 2^scale, mag nonzero and at most 24 bits
  function automatic fp32_t pack_fp(input logic sgn, input int scale, input logic [23:0] mag);
    int          msb;
    int          i;
    logic [23:0] norm;
    msb = 0;
    for (i = 0; i < 24; i++) begin
      if (mag[i]) msb = i;
    end
    norm = mag << (23 - msb);  // hidden bit to 23
    return {sgn, 8'(msb + scale + EXP_BIAS), norm[MANT_BITS-1:0]};
  endfunction

  // holds valid and data until the dut takes the item
  task automatic issue_op(input fp32_t a, input fp32_t b, input op_e o,
                          input logic [TagWidth-1:0] t);
    logic taken;
    operand_a = a;
    operand_b = b;
    op        = o;
    tag       = t;
    in_valid  = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;  // transfer on the coming edge
      next_drive();
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_result(output fp32_t r, output status_t s,
                                output logic [TagWidth-1:0] t);
    logic got;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        got = 1'b1;
        r   = result;
        s   = status;
        t   = tag_out;
      end
      next_drive();
    end
  endtask

  // one operation end to end with a fresh tag
  task automatic run_op(input fp32_t a, input fp32_t b, input op_e o,
                        input fp32_t exp_res, input status_t exp_st, input string name);
    fp32_t               res;
    status_t             st;
    logic [TagWidth-1:0] t;
    logic [TagWidth-1:0] issued;
    issued  = tag_seq;
    tag_seq = tag_seq + 1'b1;
    issue_op(a, b, o, issued);
    collect_result(res, st, t);
    check_val(res, exp_res, {name, " result"});
    check_val(32'(st), 32'(exp_st), {name, " status"});
    check_val(32'(t), 32'(issued), {name, " tag"});
  endtask

  `include "tb_divsqrt_tests.svh"

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    operand_a = '0;
    operand_b = '0;
    op        = OP_DIV;
    tag       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    tag_seq   = '0;
    lcg_state = 32'h051db204;
    repeat (3) @(posedge clk);  // reset for 3 cycles
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_val(32'(out_valid), 32'd0, "out_valid after reset");
    check_val(32'(busy), 32'd0, "busy after reset");
    check_val(32'(in_ready), 32'd1, "in_ready after reset");
    next_drive();
    exact_div_cases();
    random_div_cases();
    sqrt_cases();
    div_special_cases();
    backpressure_order();
    flush_abort();
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) $display("Finished with no errors");
    else              $display("Finished with errors");
    $finish;
  end

  // stuck handshake guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Simulation timed out after %0d cycles, a handshake never completed",
               cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+verif
common/divsqrt_pkg.sv
common/divsqrt_unit_if.sv
src/elastic_pipe.sv
divsqrt_unit/divsqrt_iter.sv
divsqrt_unit/divsqrt_round.sv
divsqrt_unit/divsqrt_unit.sv
src/divsqrt_ctrl.sv
src/divsqrt_top.sv
verif/tb_divsqrt.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divsqrt testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_divsqrt \
  -Mdir "$BUILD_DIR" -o Vtb_divsqrt
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_divsqrt" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
